// ==== source/spmv_pkg.sv ====
// SpMV shared definitions
package spmv_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////
    localparam int max_dim_len = 64;            // Max rows and vector length
    localparam int dim_w       = 7;             // Holds 0..64
    localparam int nnz_w       = 16;
    localparam int addr_w      = 32;            // Word addresses
    localparam int data_w      = 32;
    localparam int cmd_w       = 64;            // Command payload
    localparam int fifo_depth  = 4;
    localparam int fifo_ptr_w  = $clog2(fifo_depth);

    // Command type, two bits
    typedef enum logic [1:0] {
        op_init,                                // Matrix base pointer
        op_ld_spm,                              // Nonzero and row counts
        op_ld_vec,                              // Vector pointer and length
        op_get_result                           // Start readback
    } spmv_op_t;

    ////////////////////////////////////////
    // Command payload views
    ////////////////////////////////////////
    typedef struct packed {
        logic [cmd_w-addr_w-1:0] rsvd;
        logic [addr_w-1:0]       base;
    } ptr_view_t;

    typedef struct packed {
        logic [cmd_w-nnz_w-dim_w-1:0] rsvd;
        logic [dim_w-1:0]             nr;       // Bits 22..16
        logic [nnz_w-1:0]             nnz;      // Bits 15..0
    } spm_view_t;

    typedef struct packed {
        logic [cmd_w-addr_w-dim_w-1:0] rsvd;
        logic [dim_w-1:0]              len;     // Bits 38..32
        logic [addr_w-1:0]             adr;
    } vec_view_t;

    // Same 64 bits, decoded by opcode
    typedef union packed {
        ptr_view_t ptr;
        spm_view_t spm;
        vec_view_t vec;
    } cmd_cfg_u;

    // Operation configuration
    typedef struct packed {
        logic [addr_w-1:0] base;                // Values array, cols and row lengths follow
        logic [nnz_w-1:0]  nnz;
        logic [dim_w-1:0]  nr;
        logic [addr_w-1:0] vec_ptr;
        logic [dim_w-1:0]  vec_len;
    } spmv_cfg_t;

    // Wishbone classic read side
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic [addr_w-1:0] adr;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic [data_w-1:0] dat;
    } wb_rsp_t;

    // One matrix element on its way to the accumulator
    typedef struct packed {
        logic [data_w-1:0] val;
        logic [dim_w-2:0]  col;
        logic              last;                // Final element of its row
    } spmv_elem_t;

    // Vector store write port
    typedef struct packed {
        logic              en;
        logic [dim_w-2:0]  idx;
        logic [data_w-1:0] dat;
    } vec_wr_t;

endpackage

// ==== source/spmv_cmd_ctrl.sv ====
// SpMV command controller
`timescale 1ns/1ps

module spmv_cmd_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cmd_val,
    input  spmv_pkg::spmv_op_t  cmd_op,
    input  spmv_pkg::cmd_cfg_u  cmd_cfg,
    output logic                busy,           // Acts as command not-ready
    output spmv_pkg::spmv_cfg_t cfg,
    output logic                start,          // One cycle, on INIT
    output logic                prefetch_en,
    output logic                fetch_en,
    input  logic                prefetch_done,
    input  logic                rows_done,
    output logic                readback_en,
    input  logic                readback_done
);
    import spmv_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_init,                                // Waiting for both LD commands
        st_prefetch,                            // Dense vector load
        st_compute,                             // Matrix streaming
        st_finished,                            // Results ready
        st_readback
    } state_t;

    state_t state;
    logic   seen_spm, seen_vec;                 // LD commands received since INIT
    logic   cmd_hsk;
    logic   ld_ok;

    assign cmd_hsk = cmd_val && !busy;
    assign ld_ok   = cmd_hsk && (state == st_init); // LD only counts after INIT
    // INIT is taken in every non-busy state
    assign start   = cmd_hsk && (cmd_op == op_init);

    // Phase enables straight from the state
    assign busy        = (state == st_prefetch) || (state == st_compute) ||
                         (state == st_readback);
    assign prefetch_en = (state == st_prefetch);
    assign fetch_en    = (state == st_compute);
    assign readback_en = (state == st_readback);

    ////////////////////////////////////////
    // Operation state machine
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= st_idle;
            seen_spm <= 1'b0;
            seen_vec <= 1'b0;
        end else begin
            case (state)
                st_idle:     if (start) state <= st_init;
                st_init:     if (seen_spm && seen_vec && !start) state <= st_prefetch;
                st_prefetch: if (prefetch_done) state <= st_compute;
                st_compute:  if (rows_done) state <= st_finished;
                st_finished: begin
                    if (start) begin
                        state <= st_init;       // Restart with a new matrix
                    end else if (cmd_hsk && (cmd_op == op_get_result)) begin
                        state <= st_readback;
                    end
                end
                st_readback: if (readback_done) state <= st_idle;
                default:     state <= st_idle;
            endcase

            // Seen flags, either order
            if (start) begin
                seen_spm <= 1'b0;
                seen_vec <= 1'b0;
            end else if (ld_ok) begin
                if (cmd_op == op_ld_spm) seen_spm <= 1'b1;
                if (cmd_op == op_ld_vec) seen_vec <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Configuration registers
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (start) cfg.base <= cmd_cfg.ptr.base;
        if (ld_ok && (cmd_op == op_ld_spm)) begin
            cfg.nnz <= cmd_cfg.spm.nnz;
            cfg.nr  <= cmd_cfg.spm.nr;
        end
        if (ld_ok && (cmd_op == op_ld_vec)) begin
            cfg.vec_ptr <= cmd_cfg.vec.adr;
            cfg.vec_len <= cmd_cfg.vec.len;
        end
    end

endmodule

// ==== source/spmv_mem_fetch.sv ====
// SpMV memory fetch
`timescale 1ns/1ps

module spmv_mem_fetch (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic                 prefetch_en,
    input  logic                 fetch_en,
    input  spmv_pkg::spmv_cfg_t  cfg,
    output spmv_pkg::wb_req_t    wb_req,
    input  spmv_pkg::wb_rsp_t    wb_rsp,
    output spmv_pkg::vec_wr_t    vec_wr,
    output logic                 prefetch_done,
    output spmv_pkg::spmv_elem_t elem,
    output logic                 elem_valid,
    input  logic                 elem_ready
);
    import spmv_pkg::*;

    typedef enum logic [2:0] {
        f_idle,
        f_vec,                                  // Vector word reads
        f_vdone,                                // Prefetch done pulse
        f_wait,                                 // Between rows
        f_len,                                  // Row length read
        f_val,                                  // Element value read
        f_col,                                  // Column index read
        f_push                                  // Element offered to the FIFO
    } fstate_t;

    fstate_t           state;
    logic [dim_w-1:0]  vec_idx;
    logic [dim_w-1:0]  row_idx;
    logic [nnz_w-1:0]  elem_idx;                // Running element index over all rows
    logic [nnz_w-1:0]  row_rem;                 // Elements left in this row
    logic [data_w-1:0] val_q;
    logic [addr_w-1:0] rd_adr;
    logic              bus_state;
    logic              ack;

    assign bus_state = (state == f_vec) || (state == f_len) ||
                       (state == f_val) || (state == f_col);
    assign ack       = wb_req.cyc && wb_rsp.ack;

    ////////////////////////////////////////
    // Bus address select
    ////////////////////////////////////////
    always_comb begin
        case (state)
            f_vec:   rd_adr = cfg.vec_ptr + addr_w'(vec_idx);
            f_len:   rd_adr = cfg.base + addr_w'({cfg.nnz, 1'b0}) + addr_w'(row_idx);
            f_val:   rd_adr = cfg.base + addr_w'(elem_idx);
            default: rd_adr = cfg.base + addr_w'(cfg.nnz) + addr_w'(elem_idx); // Cols
        endcase
    end

    // Vector word goes straight into the store
    assign vec_wr        = '{en: (state == f_vec) && ack, idx: vec_idx[dim_w-2:0],
                             dat: wb_rsp.dat};
    assign prefetch_done = (state == f_vdone);
    assign elem_valid    = (state == f_push);

    always_ff @(posedge clk) begin
        if (!rst_n || start) begin
            state    <= f_idle;
            wb_req   <= '0;
            vec_idx  <= '0;
            row_idx  <= '0;
            elem_idx <= '0;
            row_rem  <= '0;
        end else begin
            // One read at a time, idle cycle after every ack
            if (bus_state && !wb_req.cyc) begin
                wb_req <= '{cyc: 1'b1, stb: 1'b1, adr: rd_adr};
            end else if (ack) begin
                wb_req.cyc <= 1'b0;
                wb_req.stb <= 1'b0;
            end

            case (state)
                f_idle: begin
                    if (prefetch_en) state <= (cfg.vec_len == '0) ? f_vdone : f_vec;
                end
                f_vec: begin
                    if (ack) begin
                        vec_idx <= vec_idx + 1'b1;
                        if (vec_idx + 1'b1 == cfg.vec_len) state <= f_vdone;
                    end
                end
                f_vdone: state <= f_wait;
                f_wait: begin
                    if (fetch_en && (row_idx != cfg.nr)) state <= f_len; // Rows left
                end
                f_len: begin
                    if (ack) begin
                        row_rem <= wb_rsp.dat[nnz_w-1:0];
                        // Empty row pushes a single zero element
                        state   <= (wb_rsp.dat[nnz_w-1:0] == '0) ? f_push : f_val;
                    end
                end
                f_val: if (ack) state <= f_col;
                f_col: begin
                    if (ack) begin
                        elem_idx <= elem_idx + 1'b1;
                        row_rem  <= row_rem - 1'b1;
                        state    <= f_push;
                    end
                end
                f_push: begin
                    if (elem_ready) begin
                        if (elem.last) begin
                            row_idx <= row_idx + 1'b1;
                            state   <= f_wait;
                        end else begin
                            state   <= f_val;
                        end
                    end
                end
                default: state <= f_idle;
            endcase
        end
    end

    // Element payload
    always_ff @(posedge clk) begin
        if ((state == f_val) && ack) val_q <= wb_rsp.dat;
        if ((state == f_len) && ack) elem <= '{val: '0, col: '0, last: 1'b1};
        if ((state == f_col) && ack) begin
            elem <= '{val: val_q, col: wb_rsp.dat[dim_w-2:0], last: (row_rem == 1)};
        end
    end

endmodule

// ==== source/spmv_elem_fifo.sv ====
// SpMV element FIFO
`timescale 1ns/1ps

module spmv_elem_fifo (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  spmv_pkg::spmv_elem_t in_elem,
    input  logic                 in_valid,
    output logic                 in_ready,
    output spmv_pkg::spmv_elem_t out_elem,
    output logic                 out_valid,
    input  logic                 out_ready
);
    import spmv_pkg::*;

    spmv_elem_t          mem [fifo_depth];      // Circular storage
    logic [fifo_ptr_w-1:0] wr_ptr, rd_ptr;      // Wrap on their own
    logic [fifo_ptr_w:0]   count;
    logic                  wr, rd;

    assign out_valid = (count != '0);
    assign out_elem  = mem[rd_ptr];
    // Full still takes a write when the head leaves this cycle
    assign in_ready  = (count != fifo_depth) || out_ready;

    assign wr = in_valid && in_ready;
    assign rd = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) wr_ptr <= wr_ptr + 1'b1;
            if (rd) rd_ptr <= rd_ptr + 1'b1;
            if (wr && !rd) count <= count + 1'b1;
            else if (rd && !wr) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr) mem[wr_ptr] <= in_elem;
    end

endmodule

// ==== source/spmv_row_acc.sv ====
// SpMV row accumulator
`timescale 1ns/1ps

module spmv_row_acc (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  spmv_pkg::spmv_cfg_t           cfg,
    input  spmv_pkg::vec_wr_t             vec_wr,
    input  spmv_pkg::spmv_elem_t          head,
    input  logic                          head_valid,
    output logic                          head_ready,
    output logic                          rows_done,
    input  logic                          readback_en,
    output logic                          readback_done,
    output logic                          resp_val,
    input  logic                          resp_rdy,
    output logic [spmv_pkg::data_w-1:0]   resp_data
);
    import spmv_pkg::*;

    logic [data_w-1:0] vec_mem [max_dim_len];   // Dense vector
    logic [data_w-1:0] res_mem [max_dim_len];   // One result per row
    logic [data_w-1:0] acc;                     // Running row sum
    logic [data_w-1:0] prod, sum;
    logic [dim_w-1:0]  row_cnt;
    logic [dim_w-1:0]  rd_idx;
    logic              take;
    logic              resp_hsk;

    ////////////////////////////////////////
    // Multiply-accumulate
    ////////////////////////////////////////
    assign prod = head.val * vec_mem[head.col];  // Low 32 bits only
    assign sum  = acc + prod;

    assign rows_done  = (row_cnt == cfg.nr);
    assign head_ready = !rows_done;             // One element per cycle until done
    assign take       = head_valid && head_ready;

    always_ff @(posedge clk) begin
        if (vec_wr.en) vec_mem[vec_wr.idx] <= vec_wr.dat;
        if (take && head.last) res_mem[row_cnt[dim_w-2:0]] <= sum;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || start) begin
            acc     <= '0;
            row_cnt <= '0;
        end else if (take) begin
            if (head.last) begin
                acc     <= '0;                  // Next row starts clean
                row_cnt <= row_cnt + 1'b1;
            end else begin
                acc     <= sum;
            end
        end
    end

    ////////////////////////////////////////
    // Result readback
    ////////////////////////////////////////
    assign resp_val  = readback_en && (rd_idx != cfg.nr);
    assign resp_data = res_mem[rd_idx[dim_w-2:0]]; // Holds while stalled
    assign resp_hsk  = resp_val && resp_rdy;
    // Final transfer, or nothing to return at all
    assign readback_done = readback_en &&
                           ((resp_hsk && (rd_idx + 1'b1 == cfg.nr)) || (rd_idx == cfg.nr));

    always_ff @(posedge clk) begin
        if (!rst_n || start) begin
            rd_idx <= '0;
        end else if (resp_hsk) begin
            rd_idx <= rd_idx + 1'b1;
        end
    end

endmodule

// ==== source/spmv_top.sv ====
// SpMV accelerator top
`timescale 1ns/1ps

module spmv_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cmd_val,
    input  spmv_pkg::spmv_op_t          cmd_op,
    input  spmv_pkg::cmd_cfg_u          cmd_cfg,
    output logic                        busy,
    output logic                        resp_val,
    input  logic                        resp_rdy,
    output logic [spmv_pkg::data_w-1:0] resp_data,
    output spmv_pkg::wb_req_t           wb_req,
    output logic                        wb_we,
    input  spmv_pkg::wb_rsp_t           wb_rsp
);
    import spmv_pkg::*;

    spmv_cfg_t  cfg;
    vec_wr_t    vec_wr;
    spmv_elem_t elem, head;
    logic       start, prefetch_en, fetch_en, readback_en;
    logic       prefetch_done, rows_done, readback_done;
    logic       elem_valid, elem_ready, head_valid, head_ready;

    assign wb_we = 1'b0;                        // Read-only master

    spmv_cmd_ctrl u_ctrl (
        .clk, .rst_n, .cmd_val, .cmd_op, .cmd_cfg, .busy, .cfg, .start,
        .prefetch_en, .fetch_en, .prefetch_done, .rows_done,
        .readback_en, .readback_done
    );

    // Producer
    spmv_mem_fetch u_fetch (
        .clk, .rst_n, .start, .prefetch_en, .fetch_en, .cfg, .wb_req, .wb_rsp,
        .vec_wr, .prefetch_done, .elem, .elem_valid, .elem_ready
    );

    spmv_elem_fifo u_fifo (
        .clk, .rst_n, .flush(start),
        .in_elem(elem), .in_valid(elem_valid), .in_ready(elem_ready),
        .out_elem(head), .out_valid(head_valid), .out_ready(head_ready)
    );

    // Consumer
    spmv_row_acc u_acc (
        .clk, .rst_n, .start, .cfg, .vec_wr, .head, .head_valid, .head_ready,
        .rows_done, .readback_en, .readback_done, .resp_val, .resp_rdy, .resp_data
    );

endmodule

// ==== bench/tb_clock_gen.sv ====
// Testbench clock source
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    initial clk = 1'b0;

    // 10 ns period
    always #5 clk = ~clk;

endmodule

// ==== bench/spmv_asserts.sv ====
// SpMV protocol assertions
`timescale 1ns/1ps

module spmv_asserts (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        busy,
    input logic                        resp_val,
    input logic                        resp_rdy,
    input logic [spmv_pkg::data_w-1:0] resp_data,
    input spmv_pkg::wb_req_t           wb_req,
    input spmv_pkg::wb_rsp_t           wb_rsp
);

    ////////////////////////////////////////
    // Wishbone master side
    ////////////////////////////////////////
    a_adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_req.stb && !wb_rsp.ack) |=> $stable(wb_req.adr))  // Held until ack
        else $error("wishbone address moved before ack");

    a_stb_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_req.stb |-> wb_req.cyc)
        else $error("wishbone stb high without cyc");

    ////////////////////////////////////////
    // Response port and reset
    ////////////////////////////////////////
    a_resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_data)))
        else $error("response changed while stalled");

    // First cycle out of reset
    a_busy_reset: assert property (@(posedge clk) $rose(rst_n) |-> !busy)
        else $error("busy high right after reset");

endmodule

bind spmv_top spmv_asserts u_asserts (
    .clk(clk), .rst_n(rst_n), .busy(busy), .resp_val(resp_val), .resp_rdy(resp_rdy),
    .resp_data(resp_data), .wb_req(wb_req), .wb_rsp(wb_rsp)
);

// ==== bench/tb_top.sv ====
// SpMV testbench
`timescale 1ns/1ps

module tb_top;
    import spmv_pkg::*;

    localparam int mem_words = 256;             // Memory image size
    localparam int pat_words = 512;
    localparam int desc_base = 256;             // Test count and the records after it

    logic              clk;
    logic              rst_n = 1'b0;
    logic              cmd_val = 1'b0;
    spmv_op_t          cmd_op = op_init;
    cmd_cfg_u          cmd_cfg = '0;
    logic              busy, resp_val, wb_we;
    logic              resp_rdy = 1'b1;
    logic [data_w-1:0] resp_data;
    wb_req_t           wb_req;
    wb_rsp_t           wb_rsp = '0;

    logic [31:0] pat [pat_words];               // Memory image and test records
    logic [31:0] lfsr = 32'h45ed_ba1d;
    int          rec_q [$];                     // Word index of each record
    int          errors = 0, checks = 0, cycles = 0, cycle_limit = 0;
    logic        waits_on = 1'b0, stalls_on = 1'b0;
    logic        in_xfer = 1'b0;
    logic [1:0]  wait_left = 2'b00;
    logic        ack_next;
    logic [31:0] dat_next;

    tb_clock_gen u_clk (.clk(clk));

    spmv_top uut (
        .clk, .rst_n, .cmd_val, .cmd_op, .cmd_cfg, .busy, .resp_val, .resp_rdy,
        .resp_data, .wb_req, .wb_we, .wb_rsp
    );

    ////////////////////////////////////////
    // Random bits and compare tasks
    ////////////////////////////////////////
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // Taps 32,22,2,1
    endfunction

    function automatic logic rand_bit();
        lfsr = lfsr_step(lfsr);
        return lfsr[0];
    endfunction

    task automatic check_result(input string name, input logic [data_w-1:0] exp,
                                input logic [data_w-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    ////////////////////////////////////////
    // Wishbone slave memory
    ////////////////////////////////////////
    function automatic logic [31:0] read_word(input logic [addr_w-1:0] adr);
        if (adr >= addr_w'(mem_words)) begin
            errors++;
            $display("bus read outside the memory image at address %h", adr);
            return 32'h0;
        end
        return pat[adr[7:0]];
    endfunction

    always @(posedge clk) begin
        ack_next = 1'b0;
        dat_next = wb_rsp.dat;
        if (!rst_n) begin
            in_xfer = 1'b0;
        end else if (!wb_rsp.ack && wb_req.cyc && wb_req.stb) begin
            if (!in_xfer) begin                 // New transfer draws its wait states
                in_xfer   = 1'b1;
                wait_left = 2'b00;
                if (waits_on) begin
                    wait_left[1] = rand_bit();
                    wait_left[0] = rand_bit();
                end
            end
            if (wait_left == 2'b00) begin
                in_xfer  = 1'b0;
                ack_next = 1'b1;
                dat_next = read_word(wb_req.adr);
                check_flag("wb_we during read", 1'b0, wb_we);
            end else begin
                wait_left = wait_left - 2'b01;
            end
        end
        #1;
        wb_rsp.ack = ack_next;                  // One-cycle ack
        wb_rsp.dat = dat_next;
    end

    // Run limit from the pattern workload
    initial begin
        while (cycle_limit == 0 || cycles <= cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
        $display("checks %0d errors %0d", checks, errors + 1);
        $display(">>> FAIL");
        $finish;
    end

    ////////////////////////////////////////
    // Command and response sequences
    ////////////////////////////////////////
    task automatic send_cmd(input spmv_op_t op, input logic [63:0] payload);
        cmd_val = 1'b1;
        cmd_op  = op;
        cmd_cfg = payload;
        @(posedge clk);
        while (busy) @(posedge clk);            // Taken on an edge with busy low
        #1;
        cmd_val = 1'b0;
    endtask

    task automatic run_config(input int rec, input logic vec_first);
        logic [31:0] base, nnz, nr, vptr, vlen;
        logic [63:0] spm_word, vec_word;
        base     = pat[rec];
        nnz      = pat[rec+1];
        nr       = pat[rec+2];
        vptr     = pat[rec+3];
        vlen     = pat[rec+4];
        spm_word = {41'h0, nr[6:0], nnz[15:0]}; // nr 22..16, nnz 15..0
        vec_word = {25'h0, vlen[6:0], vptr};    // len 38..32, address 31..0
        send_cmd(op_init, {32'h0, base});
        if (vec_first) begin
            send_cmd(op_ld_vec, vec_word);
            send_cmd(op_ld_spm, spm_word);
        end else begin
            send_cmd(op_ld_spm, spm_word);
            send_cmd(op_ld_vec, vec_word);
        end
    endtask

    task automatic wait_compute(input int t);
        repeat (2) @(posedge clk);              // Prefetch state from the edge after the last LD
        check_flag($sformatf("test %0d busy after configuration", t), 1'b1, busy);
        while (busy) begin
            check_flag($sformatf("test %0d resp_val during compute", t), 1'b0, resp_val);
            @(posedge clk);
        end
        #1;
    endtask

    task automatic read_results(input int t, input int rec);
        int nr, got;
        nr  = int'(pat[rec+2][6:0]);
        got = 0;
        send_cmd(op_get_result, 64'h0);
        while (got < nr) begin
            resp_rdy = stalls_on ? rand_bit() : 1'b1;
            @(posedge clk);
            if (!resp_val) begin
                errors++;
                $display("test %0d: resp_val fell after %0d of %0d results", t, got, nr);
                got = nr;
            end else if (resp_rdy) begin
                check_result($sformatf("test %0d row %0d", t, got), pat[rec+5+got], resp_data);
                got++;
            end
            #1;
        end
        resp_rdy = 1'b1;
        @(posedge clk);
        check_flag($sformatf("test %0d resp_val after last result", t), 1'b0, resp_val);
        check_flag($sformatf("test %0d busy after readback", t), 1'b0, busy);
        #1;
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        int n_tests, ptr, work;
        for (int i = 0; i < pat_words; i++) pat[i] = 32'hc0de_0000 + 32'(i);
        $readmemh("bench/spmv_patterns.hex", pat);
        n_tests = int'(pat[desc_base]);
        if (n_tests < 1 || n_tests > 16) begin
            errors++;
            $display("pattern file holds no usable test count");
            n_tests = 0;
        end
        ptr  = desc_base + 1;
        work = 0;
        for (int t = 0; t < n_tests; t++) begin
            rec_q.push_back(ptr);
            work += int'(pat[ptr+1]) + int'(pat[ptr+2]);     // Elements plus rows
            ptr  += 5 + int'(pat[ptr+2]);
        end
        if (n_tests > 0) work += int'(pat[rec_q[0]+1]) + int'(pat[rec_q[0]+2]);
        cycle_limit = 200 * work;

        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        check_flag("busy after reset", 1'b0, busy);
        check_flag("resp_val after reset", 1'b0, resp_val);
        #1;

        for (int t = 0; t < n_tests; t++) begin
            waits_on  = (t >= 2);               // Random ack delays from test 2
            stalls_on = (t >= 3);               // Random resp_rdy from test 3
            if (t == n_tests - 1 && t > 0) begin
                // Unread run first so that the next INIT arrives in finished
                run_config(rec_q[0], 1'b0);
                wait_compute(t);
            end
            run_config(rec_q[t], t == 1);
            wait_compute(t);
            read_results(t, rec_q[t]);
        end

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== bench/spmv_patterns.hex ====
// Words 0..255: memory image of values, column indices, row lengths and vectors
// From word 256: test count, then base nnz nr vec_ptr vec_len and nr row results
@000
00000002 00000003 00000005 00000007
00000000 00000002 00000001 00000003
00000002 00000001 00000001
@020
00000010 00000020 00000030 00000040
00000005 00000006 00000007 00000008
@040
00000004 00000001 00000002
00000001 00000000 00000002
00000001 00000000 00000002 00000000
@060
00000003 00000100 00000007
@080
ffffffff 10000000 00000003 80000001 00000002
00000000 00000001 00000002 00000002 00000000
00000003 00000002
@0a0
00000002 00000010 80000000
@0c0
00000011 00000022 00000033 00000044 00000055 00000066
00000000 00000001 00000000 00000001 00000001 00000000
00000001 00000001 00000002 00000001 00000001
@0e0
00000100 00001000
@100
00000005
00000000 00000004 00000003 00000020 00000004 000000b0 000000a0 000001c0
00000040 00000003 00000004 00000060 00000003 00000400 00000000 00000011 00000000
00000080 00000005 00000002 000000a0 00000003 7ffffffe 80000004
000000c0 00000006 00000005 000000e0 00000002 00001100 00022000 00047300 00055000 00006600
00000000 00000004 00000003 00000024 00000004 0000001f 0000001e 00000038

// ==== files.f ====
source/spmv_pkg.sv
source/spmv_cmd_ctrl.sv
source/spmv_mem_fetch.sv
source/spmv_elem_fifo.sv
source/spmv_row_acc.sv
source/spmv_top.sv
bench/tb_clock_gen.sv
bench/spmv_asserts.sv
bench/tb_top.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_top
FILELIST  := files.f
BUILD     := obj_dir
LOG       := sim.log
BIN       := $(BUILD)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	@$(BIN) > $(LOG) 2>&1; st=$$?; cat $(LOG); \
	if [ $$st -ne 0 ] || grep -q ">>> FAIL" $(LOG); then \
		echo "simulation reported errors"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
